// ==== hw/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] Word;
	typedef logic [4:0] RegAddr;
	typedef logic [5:0] Opcode;
	typedef logic [5:0] Funct;

	// Major opcodes
	localparam Opcode OpSpecial = 6'h00;
	localparam Opcode OpJ = 6'h02;
	localparam Opcode OpBeq = 6'h04;
	localparam Opcode OpBne = 6'h05;
	localparam Opcode OpAddi = 6'h08;
	localparam Opcode OpAddiu = 6'h09;
	localparam Opcode OpSlti = 6'h0a;
	localparam Opcode OpSltiu = 6'h0b;
	localparam Opcode OpAndi = 6'h0c;
	localparam Opcode OpOri = 6'h0d;
	localparam Opcode OpXori = 6'h0e;
	localparam Opcode OpLui = 6'h0f;
	localparam Opcode OpLw = 6'h23;
	localparam Opcode OpSw = 6'h2b;

	// SPECIAL function field
	localparam Funct FnSll = 6'h00;
	localparam Funct FnSrl = 6'h02;
	localparam Funct FnAdd = 6'h20;
	localparam Funct FnAddu = 6'h21;
	localparam Funct FnSub = 6'h22;
	localparam Funct FnSubu = 6'h23;
	localparam Funct FnAnd = 6'h24;
	localparam Funct FnOr = 6'h25;
	localparam Funct FnXor = 6'h26;
	localparam Funct FnNor = 6'h27;
	localparam Funct FnSlt = 6'h2a;
	localparam Funct FnSltu = 6'h2b;

	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr = 4'd1,
		aluAdd = 4'd2,
		aluNor = 4'd3,
		aluXor = 4'd4,
		aluSub = 4'd6,
		aluSlt = 4'd7,
		aluSll = 4'd10,
		aluSrl = 4'd13,
		aluSltu = 4'd14
	} AluOp;

	typedef enum logic {aRs, aRt} ASrc; // aRt for shifts
	typedef enum logic [2:0] {bRt, bImmSext, bImmZext, bShamt, bImmHigh} BSrc;
	typedef enum logic {dstRt, dstRd} RegDst;
	typedef enum logic {wbAlu, wbMem} WbSrc;

	typedef struct packed {
		AluOp aluOp;
		ASrc aSrc;
		BSrc bSrc;
		RegDst regDst;
		WbSrc wbSrc;
		logic regWrite;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
	} CtrlBundle;

	typedef struct packed {
		logic en;
		RegAddr addr;
		Word data;
	} WriteBack;

endpackage

// ==== hw/instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch (
	input logic Clk,
	input logic rst,
	input mipsPkg::Word instr,
	input logic branchTaken,
	input logic jump,
	output mipsPkg::Word pc
);

	mipsPkg::Word pcPlus4;
	mipsPkg::Word branchTarget;
	mipsPkg::Word jumpTarget;
	mipsPkg::Word nextPc;

	assign pcPlus4 = pc + 32'd4;

	// Word offset relative to the following instruction
	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};

	// Stays inside the current 256 MB region
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		if (jump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// ==== hw/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
	input mipsPkg::Word instr,
	output mipsPkg::CtrlBundle ctrl
);

	// Writes nothing, stores nothing, falls through to pc + 4
	localparam mipsPkg::CtrlBundle CtrlNop = '{
		aluOp: mipsPkg::aluAdd,
		aSrc: mipsPkg::aRs,
		bSrc: mipsPkg::bRt,
		regDst: mipsPkg::dstRt,
		wbSrc: mipsPkg::wbAlu,
		regWrite: 1'b0,
		memWrite: 1'b0,
		branchEq: 1'b0,
		branchNe: 1'b0,
		jump: 1'b0
	};

	mipsPkg::Opcode opcode;
	mipsPkg::Funct funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		ctrl = CtrlNop;
		if (instr != '0) begin // All-zero word stays a no-op
			case (opcode)
				mipsPkg::OpSpecial: begin
					ctrl.regDst = mipsPkg::dstRd;
					ctrl.regWrite = 1'b1;
					case (funct)
						mipsPkg::FnSll: begin
							ctrl.aluOp = mipsPkg::aluSll;
							ctrl.aSrc = mipsPkg::aRt;
							ctrl.bSrc = mipsPkg::bShamt;
						end
						mipsPkg::FnSrl: begin
							ctrl.aluOp = mipsPkg::aluSrl;
							ctrl.aSrc = mipsPkg::aRt;
							ctrl.bSrc = mipsPkg::bShamt;
						end
						mipsPkg::FnAdd, mipsPkg::FnAddu: ctrl.aluOp = mipsPkg::aluAdd; // No trap
						mipsPkg::FnSub, mipsPkg::FnSubu: ctrl.aluOp = mipsPkg::aluSub;
						mipsPkg::FnAnd: ctrl.aluOp = mipsPkg::aluAnd;
						mipsPkg::FnOr: ctrl.aluOp = mipsPkg::aluOr;
						mipsPkg::FnXor: ctrl.aluOp = mipsPkg::aluXor;
						mipsPkg::FnNor: ctrl.aluOp = mipsPkg::aluNor;
						mipsPkg::FnSlt: ctrl.aluOp = mipsPkg::aluSlt;
						mipsPkg::FnSltu: ctrl.aluOp = mipsPkg::aluSltu;
						default: ctrl.regWrite = 1'b0;
					endcase
				end
				mipsPkg::OpAddi, mipsPkg::OpAddiu: begin
					ctrl.bSrc = mipsPkg::bImmSext;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpSlti: begin
					ctrl.aluOp = mipsPkg::aluSlt;
					ctrl.bSrc = mipsPkg::bImmSext;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpSltiu: begin
					ctrl.aluOp = mipsPkg::aluSltu;
					ctrl.bSrc = mipsPkg::bImmSext; // Sign extended, compared unsigned
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpAndi: begin
					ctrl.aluOp = mipsPkg::aluAnd;
					ctrl.bSrc = mipsPkg::bImmZext;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpOri: begin
					ctrl.aluOp = mipsPkg::aluOr;
					ctrl.bSrc = mipsPkg::bImmZext;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpXori: begin
					ctrl.aluOp = mipsPkg::aluXor;
					ctrl.bSrc = mipsPkg::bImmZext;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpLui: begin
					ctrl.aluOp = mipsPkg::aluSll;
					ctrl.bSrc = mipsPkg::bImmHigh;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpLw: begin
					ctrl.bSrc = mipsPkg::bImmSext;
					ctrl.wbSrc = mipsPkg::wbMem;
					ctrl.regWrite = 1'b1;
				end
				mipsPkg::OpSw: begin
					ctrl.bSrc = mipsPkg::bImmSext;
					ctrl.memWrite = 1'b1;
				end
				mipsPkg::OpBeq: begin
					ctrl.aluOp = mipsPkg::aluSub;
					ctrl.branchEq = 1'b1;
				end
				mipsPkg::OpBne: begin
					ctrl.aluOp = mipsPkg::aluSub;
					ctrl.branchNe = 1'b1;
				end
				mipsPkg::OpJ: ctrl.jump = 1'b1;
				default: ctrl = CtrlNop;
			endcase
		end
	end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic Clk,
	input logic rst,
	input mipsPkg::RegAddr rsAddr,
	input mipsPkg::RegAddr rtAddr,
	input mipsPkg::WriteBack wb,
	output mipsPkg::Word rsData,
	output mipsPkg::Word rtData
);

	mipsPkg::Word regs [32];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && (wb.addr != '0)) begin // r0 is never written
			regs[wb.addr] <= wb.data;
		end
	end

	// Plain reads, a write shows up in the following cycle
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// ==== hw/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
	input mipsPkg::Word instr,
	input mipsPkg::CtrlBundle ctrl,
	input mipsPkg::Word rsData,
	input mipsPkg::Word rtData,
	input mipsPkg::Word memRdData,
	output mipsPkg::Word memAddr,
	output mipsPkg::Word memWrData,
	output logic branchTaken,
	output mipsPkg::WriteBack wb
);

	localparam mipsPkg::Word LuiShift = 32'd16;

	mipsPkg::Word immSext;
	mipsPkg::Word immZext;
	mipsPkg::Word shamt;
	mipsPkg::Word opA;
	mipsPkg::Word opB;
	mipsPkg::Word aluResult;
	logic zero;

	assign immSext = {{16{instr[15]}}, instr[15:0]};
	assign immZext = {16'h0000, instr[15:0]};
	assign shamt = {27'h0, instr[10:6]};

	always_comb begin
		if (ctrl.bSrc == mipsPkg::bImmHigh) begin
			opA = immZext; // LUI shifts the immediate itself
		end else if (ctrl.aSrc == mipsPkg::aRt) begin
			opA = rtData;
		end else begin
			opA = rsData;
		end
	end

	always_comb begin
		case (ctrl.bSrc)
			mipsPkg::bRt: opB = rtData;
			mipsPkg::bImmSext: opB = immSext;
			mipsPkg::bImmZext: opB = immZext;
			mipsPkg::bShamt: opB = shamt;
			mipsPkg::bImmHigh: opB = LuiShift;
			default: opB = rtData;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::aluAnd: aluResult = opA & opB;
			mipsPkg::aluOr: aluResult = opA | opB;
			mipsPkg::aluAdd: aluResult = opA + opB;
			mipsPkg::aluNor: aluResult = ~(opA | opB);
			mipsPkg::aluXor: aluResult = opA ^ opB;
			mipsPkg::aluSub: aluResult = opA - opB;
			mipsPkg::aluSlt: aluResult = {31'h0, $signed(opA) < $signed(opB)};
			mipsPkg::aluSltu: aluResult = {31'h0, opA < opB};
			mipsPkg::aluSll: aluResult = opA << opB[4:0];
			mipsPkg::aluSrl: aluResult = opA >> opB[4:0];
			default: aluResult = '0;
		endcase
	end

	// Branches compare through the subtractor
	assign zero = (aluResult == '0);
	assign branchTaken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

	assign memAddr = aluResult;
	assign memWrData = rtData;

	assign wb.en = ctrl.regWrite;
	assign wb.addr = (ctrl.regDst == mipsPkg::dstRd) ? instr[15:11] : instr[20:16];
	assign wb.data = (ctrl.wbSrc == mipsPkg::wbMem) ? memRdData : aluResult;

endmodule

// ==== hw/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
	parameter int dataMemWords = 256
) (
	input logic Clk,
	input logic wrEn,
	input mipsPkg::Word addr,
	input mipsPkg::Word wrData,
	output mipsPkg::Word rdData
);

	localparam int IdxBits = $clog2(dataMemWords);

	mipsPkg::Word mem [dataMemWords];
	logic [IdxBits-1:0] wordIdx;

	// Byte offset bits ignored, upper bits wrap
	assign wordIdx = addr[IdxBits+1:2];

	always_ff @(posedge Clk) begin
		if (wrEn) begin
			mem[wordIdx] <= wrData;
		end
	end

	assign rdData = mem[wordIdx];

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore #(
	parameter int dataMemWords = 256
) (
	input logic Clk,
	input logic rst,
	input mipsPkg::Word instr,
	output mipsPkg::Word pc,
	output mipsPkg::WriteBack wb
);

	mipsPkg::CtrlBundle ctrl;
	mipsPkg::Word rsData;
	mipsPkg::Word rtData;
	mipsPkg::Word memAddr;
	mipsPkg::Word memWrData;
	mipsPkg::Word memRdData;
	mipsPkg::WriteBack exWb;
	logic branchTaken;
	logic memWrEn;

	instrFetch i_fetch (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.branchTaken(branchTaken),
		.jump(ctrl.jump),
		.pc(pc)
	);

	controlDecoder i_decoder (
		.instr(instr),
		.ctrl(ctrl)
	);

	registerFile i_regFile (
		.Clk(Clk),
		.rst(rst),
		.rsAddr(instr[25:21]),
		.rtAddr(instr[20:16]),
		.wb(wb),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeUnit i_execute (
		.instr(instr),
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.branchTaken(branchTaken),
		.wb(exWb)
	);

	dataMemory #(
		.dataMemWords(dataMemWords)
	) i_dataMem (
		.Clk(Clk),
		.wrEn(memWrEn),
		.addr(memAddr),
		.wrData(memWrData),
		.rdData(memRdData)
	);

	// No commits while in reset
	assign wb = '{en: exWb.en & ~rst, addr: exWb.addr, data: exWb.data};
	assign memWrEn = ctrl.memWrite & ~rst;

endmodule

// ==== include/programTable.svh ====
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef struct packed {
	mipsPkg::Word instr;
	mipsPkg::Word pc;
	logic wbEn;
	mipsPkg::RegAddr wbAddr;
	mipsPkg::Word wbData;
} ProgRow;

localparam int ProgLen = 31;

// Execution order, instructions skipped by a branch or jump are left out
localparam ProgRow ProgTable [ProgLen] = '{
	'{32'h00000000, 32'h00000000, 1'b0, 5'd0, 32'h00000000}, // nop
	'{32'h24010005, 32'h00000004, 1'b1, 5'd1, 32'h00000005}, // addiu r1, r0, 5
	'{32'h2002FFFD, 32'h00000008, 1'b1, 5'd2, 32'hFFFFFFFD}, // addi r2, r0, -3
	'{32'h34038001, 32'h0000000C, 1'b1, 5'd3, 32'h00008001}, // ori r3, r0, 0x8001
	'{32'h304400F0, 32'h00000010, 1'b1, 5'd4, 32'h000000F0}, // andi r4, r2, 0xf0
	'{32'h382500FF, 32'h00000014, 1'b1, 5'd5, 32'h000000FA}, // xori r5, r1, 0xff
	'{32'h2846FFFF, 32'h00000018, 1'b1, 5'd6, 32'h00000001}, // slti r6, r2, -1
	'{32'h2C27FFFF, 32'h0000001C, 1'b1, 5'd7, 32'h00000001}, // sltiu r7, r1, -1
	'{32'h3C081234, 32'h00000020, 1'b1, 5'd8, 32'h12340000}, // lui r8, 0x1234
	'{32'h00224821, 32'h00000024, 1'b1, 5'd9, 32'h00000002}, // addu r9, r1, r2
	'{32'h01285020, 32'h00000028, 1'b1, 5'd10, 32'h12340002}, // add r10, r9, r8
	'{32'h00235823, 32'h0000002C, 1'b1, 5'd11, 32'hFFFF8004}, // subu r11, r1, r3
	'{32'h00816022, 32'h00000030, 1'b1, 5'd12, 32'h000000EB}, // sub r12, r4, r1
	'{32'h00A46824, 32'h00000034, 1'b1, 5'd13, 32'h000000F0},
	'{32'h00687025, 32'h00000038, 1'b1, 5'd14, 32'h12348001},
	'{32'h00A17826, 32'h0000003C, 1'b1, 5'd15, 32'h000000FF},
	'{32'h00208027, 32'h00000040, 1'b1, 5'd16, 32'hFFFFFFFA}, // nor r16, r1, r0
	'{32'h0041882A, 32'h00000044, 1'b1, 5'd17, 32'h00000001}, // slt, -3 < 5
	'{32'h0041902B, 32'h00000048, 1'b1, 5'd18, 32'h00000000}, // sltu, same operands
	'{32'h00019900, 32'h0000004C, 1'b1, 5'd19, 32'h00000050}, // sll r19, r1, 4
	'{32'h0008A202, 32'h00000050, 1'b1, 5'd20, 32'h00123400}, // srl r20, r8, 8
	'{32'hAC0E0008, 32'h00000054, 1'b0, 5'd14, 32'h00000008}, // sw r14, 8(r0)
	'{32'h8C150008, 32'h00000058, 1'b1, 5'd21, 32'h12348001}, // lw r21, 8(r0)
	'{32'h8C160020, 32'h0000005C, 1'b1, 5'd22, 32'h00000000}, // lw of untouched word
	'{32'h10290002, 32'h00000060, 1'b0, 5'd9, 32'h00000003}, // beq r1, r9 not taken
	'{32'h14290001, 32'h00000064, 1'b0, 5'd9, 32'h00000003}, // bne r1, r9 taken
	'{32'h12270001, 32'h0000006C, 1'b0, 5'd7, 32'h00000000}, // beq r17, r7 taken
	'{32'h14210005, 32'h00000074, 1'b0, 5'd1, 32'h00000000}, // bne r1, r1 not taken
	'{32'h08000022, 32'h00000078, 1'b0, 5'd0, 32'h00000000}, // j 0x88
	'{32'h24200007, 32'h00000088, 1'b1, 5'd0, 32'h0000000C}, // addiu r0, r1, 7
	'{32'h0001B821, 32'h0000008C, 1'b1, 5'd23, 32'h00000005} // addu r23, r0, r1
};

`endif

// ==== sim/tbMipsCore.sv ====
`timescale 1ns/1ps

module tbMipsCore;

	`include "programTable.svh"

	localparam int ImemWords = 64;
	localparam int ImemIdxBits = $clog2(ImemWords);
	localparam int CycleLimit = ProgLen + 20;

	logic Clk;
	logic rst;
	mipsPkg::Word instr;
	mipsPkg::Word pc;
	mipsPkg::WriteBack wb;

	mipsPkg::Word imem [ImemWords];
	int cycles = 0;

	mipsCore #(
		.dataMemWords(256)
	) i_dut (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.pc(pc),
		.wb(wb)
	);

	// addiu r31 with an address-derived immediate, visible on wb if ever fetched
	function automatic mipsPkg::Word fillWord(mipsPkg::Word addr);
		return {16'h241F, addr[31:16] ^ addr[15:0]};
	endfunction

	function automatic mipsPkg::Word fetchWord(mipsPkg::Word addr);
		if (addr < ImemWords * 4) begin
			return imem[addr[ImemIdxBits+1:2]];
		end
		return fillWord(addr); // Outside the program space
	endfunction

	task automatic loadImem();
		for (int i = 0; i < ImemWords; i++) begin
			imem[i] = fillWord(i * 4);
		end
		for (int r = 0; r < ProgLen; r++) begin
			imem[ProgTable[r].pc[ImemIdxBits+1:2]] = ProgTable[r].instr;
		end
	endtask

	task automatic reportMismatch(string name, mipsPkg::Word expected, mipsPkg::Word actual);
		$display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
	endtask

	task automatic checkResetHold();
		assert (wb.en === 1'b0) else begin
			reportMismatch("wb.en", 32'h0, {31'h0, wb.en});
			$display("Test failed");
			$fatal(1, "wb.en active during reset");
		end
	endtask

	task automatic checkRow(ProgRow row);
		assert (pc === row.pc) else begin
			reportMismatch("pc", row.pc, pc);
			$display("Test failed");
			$fatal(1, "pc mismatch");
		end
		assert (wb.en === row.wbEn) else begin
			reportMismatch("wb.en", {31'h0, row.wbEn}, {31'h0, wb.en});
			$display("Test failed");
			$fatal(1, "wb.en mismatch");
		end
		if (row.wbEn) begin // Address and data only matter on a write
			assert (wb.addr === row.wbAddr) else begin
				reportMismatch("wb.addr", {27'h0, row.wbAddr}, {27'h0, wb.addr});
				$display("Test failed");
				$fatal(1, "wb.addr mismatch");
			end
			assert (wb.data === row.wbData) else begin
				reportMismatch("wb.data", row.wbData, wb.data);
				$display("Test failed");
				$fatal(1, "wb.data mismatch");
			end
		end
	endtask

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycles = cycles + 1;
		if (cycles > CycleLimit) begin
			$display("Run did not finish within %0d cycles", CycleLimit);
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial begin
		rst = 1'b1;
		instr = ProgTable[1].instr; // A register write held off by reset
		loadImem();
		@(negedge Clk);
		checkResetHold();
		@(posedge Clk);
		#1;
		rst = 1'b0;
		for (int r = 0; r < ProgLen; r++) begin
			instr = fetchWord(pc); // Instruction memory lookup
			@(negedge Clk);
			checkRow(ProgTable[r]);
			@(posedge Clk);
			#1;
		end
		$display("Test passed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
hw/mipsPkg.sv
hw/instrFetch.sv
hw/controlDecoder.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/dataMemory.sv
hw/mipsCore.sv
sim/tbMipsCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f build.f --top-module tbMipsCore -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
exit 0
